// File: source/pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// data path and pc width.
`define PIPE_XLEN 32
// register file address width.
`define PIPE_RBITS 5

// primary opcodes.
`define PIPE_OP_RTYPE 6'h00
`define PIPE_OP_ADDI 6'h08
`define PIPE_OP_ADDIU 6'h09
`define PIPE_OP_ANDI 6'h0c
`define PIPE_OP_ORI 6'h0d

// function codes inside the r-type group.
`define PIPE_FN_SYSCALL 6'h0c
`define PIPE_FN_BREAK 6'h0d
`define PIPE_FN_ADD 6'h20
`define PIPE_FN_ADDU 6'h21
`define PIPE_FN_SUB 6'h22
`define PIPE_FN_SUBU 6'h23
`define PIPE_FN_AND 6'h24
`define PIPE_FN_OR 6'h25

// exception codes.
`define PIPE_EXC_ADEL 5'd4
`define PIPE_EXC_SYS 5'd8
`define PIPE_EXC_BP 5'd9
`define PIPE_EXC_RI 5'd10
`define PIPE_EXC_OV 5'd12

`endif

// File: source/pipe_pkg.sv
`include "pipe_consts.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // one bit per exception source, highest priority first.
    typedef struct packed {
        logic adel;
        logic ri;
        logic sys;
        logic bp;
        logic ov;
    } exc_flags_t;

    // fetch to decode.
    typedef struct packed {
        logic [`PIPE_XLEN-1:0] ins;
    } fetch_ctrl_t;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0] pc;
    } fetch_data_t;

    // decode to execute.
    typedef struct packed {
        alu_op_t alu_op;
        logic rf_wr;
        logic use_imm;
        logic zero_ext;
        logic [`PIPE_RBITS-1:0] rw;
        exc_flags_t exc;
    } exec_ctrl_t;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0] pc;
        logic [`PIPE_XLEN-1:0] rs_val;
        logic [`PIPE_XLEN-1:0] rt_val;
        logic [15:0] imm16;
    } exec_data_t;

    // execute to result.
    typedef struct packed {
        logic rf_wr;
        logic [`PIPE_RBITS-1:0] rw;
        exc_flags_t exc;
    } result_ctrl_t;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0] pc;
        logic [`PIPE_XLEN-1:0] alu_out;
    } result_data_t;

endpackage

// File: source/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type ctrl_t = logic,
    parameter type data_t = logic,
    parameter ctrl_t bubble = ctrl_t'('0)
) (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall,
    input logic stall_up,
    input ctrl_t ctrl_in,
    input data_t data_in,
    output ctrl_t ctrl_out,
    output data_t data_out
);

    // control part, flush wins over stall.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ctrl_out <= bubble;
        else if (flush)
            ctrl_out <= bubble;
        else if (stall)
            ctrl_out <= ctrl_out;
        else if (stall_up)
            ctrl_out <= bubble;
        else
            ctrl_out <= ctrl_in;
    end

    // payload only loads or holds.
    always_ff @(posedge clk)
    begin
        if (!stall)
            data_out <= data_in;
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module decode_stage
    import pipe_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall,
    input logic [`PIPE_XLEN-1:0] pc,
    input logic [`PIPE_XLEN-1:0] ins,
    input logic ins_valid,
    output logic [`PIPE_RBITS-1:0] rs_addr,
    output logic [`PIPE_RBITS-1:0] rt_addr,
    input logic [`PIPE_XLEN-1:0] rs_data,
    input logic [`PIPE_XLEN-1:0] rt_data,
    output exec_ctrl_t ctrl,
    output exec_data_t data
);

    fetch_ctrl_t f_in;
    fetch_ctrl_t f_ctrl;
    fetch_data_t f_data;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [`PIPE_RBITS-1:0] rd;
    logic [15:0] imm;
    logic is_nop;
    logic adel;
    logic wr;
    logic [`PIPE_RBITS-1:0] dest;
    exec_ctrl_t dec;

    // invalid fetch is stored as the zero word.
    assign f_in.ins = ins_valid ? ins : '0;

    stage_reg #(
        .ctrl_t(fetch_ctrl_t),
        .data_t(fetch_data_t),
        .bubble(fetch_ctrl_t'('0))
    ) fetch_reg_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .stall(stall),
        .stall_up(1'b0),
        .ctrl_in(f_in),
        .data_in(pc),
        .ctrl_out(f_ctrl),
        .data_out(f_data)
    );

    assign opcode = f_ctrl.ins[31:26];
    assign rs_addr = f_ctrl.ins[25:21];
    assign rt_addr = f_ctrl.ins[20:16];
    assign rd = f_ctrl.ins[15:11];
    assign funct = f_ctrl.ins[5:0];
    assign imm = f_ctrl.ins[15:0];

    assign is_nop = (f_ctrl.ins == '0);
    // a bubble keeps a stale pc, so only a real word can fault.
    assign adel = !is_nop && (f_data.pc[1:0] != 2'b00);

    always_comb
    begin
        dec = '0;
        wr = 1'b0;
        dest = rd;
        if (is_nop)
        begin
            wr = 1'b0;
        end
        else if (opcode == `PIPE_OP_RTYPE)
        begin
            case (funct)
                `PIPE_FN_ADD:
                begin
                    dec.alu_op = ALU_ADD;
                    wr = 1'b1;
                end
                `PIPE_FN_ADDU:
                begin
                    dec.alu_op = ALU_ADDU;
                    wr = 1'b1;
                end
                `PIPE_FN_SUB:
                begin
                    dec.alu_op = ALU_SUB;
                    wr = 1'b1;
                end
                `PIPE_FN_SUBU:
                begin
                    dec.alu_op = ALU_SUBU;
                    wr = 1'b1;
                end
                `PIPE_FN_AND:
                begin
                    dec.alu_op = ALU_AND;
                    wr = 1'b1;
                end
                `PIPE_FN_OR:
                begin
                    dec.alu_op = ALU_OR;
                    wr = 1'b1;
                end
                `PIPE_FN_SYSCALL: dec.exc.sys = 1'b1;
                `PIPE_FN_BREAK: dec.exc.bp = 1'b1;
                default: dec.exc.ri = 1'b1;
            endcase
        end
        else
        begin
            // immediate forms write rt.
            dest = rt_addr;
            dec.use_imm = 1'b1;
            wr = 1'b1;
            case (opcode)
                `PIPE_OP_ADDI: dec.alu_op = ALU_ADD;
                `PIPE_OP_ADDIU: dec.alu_op = ALU_ADDU;
                `PIPE_OP_ANDI:
                begin
                    dec.alu_op = ALU_AND;
                    dec.zero_ext = 1'b1;
                end
                `PIPE_OP_ORI:
                begin
                    dec.alu_op = ALU_OR;
                    dec.zero_ext = 1'b1;
                end
                default:
                begin
                    dec.use_imm = 1'b0;
                    wr = 1'b0;
                    dec.exc.ri = 1'b1;
                end
            endcase
        end
        dec.rw = dest;
        dec.rf_wr = wr && (dest != '0);
        // address error leaves only its own flag.
        if (adel)
        begin
            dec = '0;
            dec.exc.adel = 1'b1;
        end
    end

    assign ctrl = dec;
    assign data.pc = f_data.pc;
    assign data.rs_val = rs_data;
    assign data.rt_val = rt_data;
    assign data.imm16 = imm;

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module execute_stage
    import pipe_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall,
    input logic stall_up,
    input exec_ctrl_t ctrl_in,
    input exec_data_t data_in,
    output result_ctrl_t ctrl,
    output result_data_t data
);

    localparam exec_ctrl_t EXEC_BUBBLE = '{
        alu_op: ALU_NOP,
        rf_wr: 1'b0,
        use_imm: 1'b0,
        zero_ext: 1'b0,
        rw: '0,
        exc: '0
    };

    exec_ctrl_t e_ctrl;
    exec_data_t e_data;
    alu_op_t op;
    logic [`PIPE_XLEN-1:0] src_a;
    logic [`PIPE_XLEN-1:0] imm_ext;
    logic [`PIPE_XLEN-1:0] src_b;
    logic [`PIPE_XLEN-1:0] sum;
    logic [`PIPE_XLEN-1:0] diff;
    logic [`PIPE_XLEN-1:0] alu_out;
    logic ov;

    stage_reg #(
        .ctrl_t(exec_ctrl_t),
        .data_t(exec_data_t),
        .bubble(EXEC_BUBBLE)
    ) exec_reg_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .stall(stall),
        .stall_up(stall_up),
        .ctrl_in(ctrl_in),
        .data_in(data_in),
        .ctrl_out(e_ctrl),
        .data_out(e_data)
    );

    // faulting fetch must not compute.
    assign op = e_ctrl.exc.adel ? ALU_NOP : e_ctrl.alu_op;

    assign src_a = e_data.rs_val;
    assign imm_ext = e_ctrl.zero_ext ? {16'b0, e_data.imm16}
                                     : {{16{e_data.imm16[15]}}, e_data.imm16};
    assign src_b = e_ctrl.use_imm ? imm_ext : e_data.rt_val;
    assign sum = src_a + src_b;
    assign diff = src_a - src_b;

    always_comb
    begin
        case (op)
            ALU_ADD, ALU_ADDU: alu_out = sum;
            ALU_SUB, ALU_SUBU: alu_out = diff;
            ALU_AND: alu_out = src_a & src_b;
            ALU_OR: alu_out = src_a | src_b;
            default: alu_out = '0;
        endcase
    end

    // signed overflow, trapping forms only.
    assign ov = ((op == ALU_ADD) && (src_a[31] == src_b[31]) && (sum[31] != src_a[31]))
             || ((op == ALU_SUB) && (src_a[31] != src_b[31]) && (diff[31] != src_a[31]));

    always_comb
    begin
        ctrl.rf_wr = e_ctrl.rf_wr && (op != ALU_NOP);
        ctrl.rw = e_ctrl.rw;
        ctrl.exc = e_ctrl.exc;
        ctrl.exc.ov = ov;
    end

    assign data.pc = e_data.pc;
    assign data.alu_out = alu_out;

endmodule

// File: source/result_stage.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module result_stage
    import pipe_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall,
    input logic stall_up,
    input result_ctrl_t ctrl_in,
    input result_data_t data_in,
    output logic wb_en,
    output logic [`PIPE_RBITS-1:0] wb_reg,
    output logic [`PIPE_XLEN-1:0] wb_data,
    output logic exc_valid,
    output logic [4:0] exc_code,
    output logic [`PIPE_XLEN-1:0] exc_pc
);

    result_ctrl_t r_ctrl;
    result_data_t r_data;

    stage_reg #(
        .ctrl_t(result_ctrl_t),
        .data_t(result_data_t),
        .bubble(result_ctrl_t'('0))
    ) result_reg_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .stall(stall),
        .stall_up(stall_up),
        .ctrl_in(ctrl_in),
        .data_in(data_in),
        .ctrl_out(r_ctrl),
        .data_out(r_data)
    );

    assign exc_valid = |r_ctrl.exc;
    // any exception cancels the write.
    assign wb_en = r_ctrl.rf_wr && !exc_valid;
    assign wb_reg = r_ctrl.rw;
    assign wb_data = r_data.alu_out;
    assign exc_pc = r_data.pc;

    // first flag in priority order picks the code.
    always_comb
    begin
        if (r_ctrl.exc.adel)
            exc_code = `PIPE_EXC_ADEL;
        else if (r_ctrl.exc.ri)
            exc_code = `PIPE_EXC_RI;
        else if (r_ctrl.exc.sys)
            exc_code = `PIPE_EXC_SYS;
        else if (r_ctrl.exc.bp)
            exc_code = `PIPE_EXC_BP;
        else if (r_ctrl.exc.ov)
            exc_code = `PIPE_EXC_OV;
        else
            exc_code = 5'd0;
    end

endmodule

// File: source/pipe_top.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module pipe_top
    import pipe_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall_decode,
    input logic stall_exec,
    input logic stall_result,
    input logic [`PIPE_XLEN-1:0] pc,
    input logic [`PIPE_XLEN-1:0] ins,
    input logic ins_valid,
    output logic [`PIPE_RBITS-1:0] rs_addr,
    output logic [`PIPE_RBITS-1:0] rt_addr,
    input logic [`PIPE_XLEN-1:0] rs_data,
    input logic [`PIPE_XLEN-1:0] rt_data,
    output logic wb_en,
    output logic [`PIPE_RBITS-1:0] wb_reg,
    output logic [`PIPE_XLEN-1:0] wb_data,
    output logic exc_valid,
    output logic [4:0] exc_code,
    output logic [`PIPE_XLEN-1:0] exc_pc
);

    exec_ctrl_t dec_ctrl;
    exec_data_t dec_data;
    result_ctrl_t ex_ctrl;
    result_data_t ex_data;

    decode_stage decode_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .stall(stall_decode),
        .pc(pc),
        .ins(ins),
        .ins_valid(ins_valid),
        .rs_addr(rs_addr),
        .rt_addr(rt_addr),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .ctrl(dec_ctrl),
        .data(dec_data)
    );

    execute_stage execute_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .stall(stall_exec),
        .stall_up(stall_decode),
        .ctrl_in(dec_ctrl),
        .data_in(dec_data),
        .ctrl(ex_ctrl),
        .data(ex_data)
    );

    result_stage result_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .stall(stall_result),
        .stall_up(stall_exec),
        .ctrl_in(ex_ctrl),
        .data_in(ex_data),
        .wb_en(wb_en),
        .wb_reg(wb_reg),
        .wb_data(wb_data),
        .exc_valid(exc_valid),
        .exc_code(exc_code),
        .exc_pc(exc_pc)
    );

endmodule

// File: bench/pipe_assert.sv
`timescale 1ns/1ps

module pipe_assert (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall_decode,
    input logic stall_exec,
    input logic stall_result,
    input logic wb_en,
    input logic exc_valid
);

    int fail_count = 0;

    // a stalled later stage implies stalled earlier stages.
    stalls_monotonic: assert property (@(posedge clk) disable iff (rst)
        (!stall_result || stall_exec) && (!stall_exec || stall_decode))
    else
    begin
        $error("stall levels are not monotonic");
        fail_count++;
    end

    wb_exc_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(wb_en && exc_valid))
    else
    begin
        $error("writeback and exception are high together");
        fail_count++;
    end

    flush_clears_outputs: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!wb_en && !exc_valid))
    else
    begin
        $error("outputs not cleared in the cycle after a flush");
        fail_count++;
    end

endmodule

bind pipe_top pipe_assert pipe_assert_i (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .stall_decode(stall_decode),
    .stall_exec(stall_exec),
    .stall_result(stall_result),
    .wb_en(wb_en),
    .exc_valid(exc_valid)
);

// File: bench/pipe_tb.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module pipe_tb;

    localparam int max_rows = 64;

    logic clk;
    logic rst;
    logic flush;
    logic stall_decode;
    logic stall_exec;
    logic stall_result;
    logic [31:0] pc;
    logic [31:0] ins;
    logic ins_valid;
    logic [4:0] rs_addr;
    logic [4:0] rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic wb_en;
    logic [4:0] wb_reg;
    logic [31:0] wb_data;
    logic exc_valid;
    logic [4:0] exc_code;
    logic [31:0] exc_pc;

    string test_name[6] = '{"alu ops", "overflow", "exceptions", "no commit",
                            "random stalls", "flush"};
    // latency is fixed only where no stall is applied.
    bit timed[6] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    int n_rows;
    int max_hold;
    int row_test[max_rows];
    logic [31:0] row_ins[max_rows];
    logic [31:0] row_pc[max_rows];
    logic row_valid[max_rows];
    int row_hold[max_rows];
    int row_lvl[max_rows];
    logic row_flush[max_rows];

    logic [37:0] exp_q[$];
    int cyc_q[$];
    logic [31:0] rng;
    int cyc = 0;
    int limit = 1000;
    int cur_test;
    int checks;
    int errors;
    int test_checks;
    int test_errors;

    pipe_top pipe_top_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .stall_decode(stall_decode),
        .stall_exec(stall_exec),
        .stall_result(stall_result),
        .pc(pc),
        .ins(ins),
        .ins_valid(ins_valid),
        .rs_addr(rs_addr),
        .rt_addr(rt_addr),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .wb_en(wb_en),
        .wb_reg(wb_reg),
        .wb_data(wb_data),
        .exc_valid(exc_valid),
        .exc_code(exc_code),
        .exc_pc(exc_pc)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // addresses 1 to 3 hold fixed operands for the overflow rows.
    function automatic logic [31:0] rf_val(input logic [4:0] a);
        case (a)
            5'd0: return 32'h0;
            5'd1: return 32'h7fff_fff0;
            5'd2: return 32'h0000_0100;
            5'd3: return 32'h8000_0010;
            default: return {a, 27'h0} ^ ({27'h0, a} * 32'h0001_9d3f) ^ 32'h3c5a_0000;
        endcase
    endfunction

    assign rs_data = rf_val(rs_addr);
    assign rt_data = rf_val(rt_addr);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {`PIPE_OP_RTYPE, rs, rt, rd, 5'h0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_ins(input logic [31:0] r);
        logic [5:0] fns[6];
        logic [5:0] ops[4];
        int sel;
        fns = '{`PIPE_FN_ADD, `PIPE_FN_ADDU, `PIPE_FN_SUB, `PIPE_FN_SUBU,
                `PIPE_FN_AND, `PIPE_FN_OR};
        ops = '{`PIPE_OP_ADDI, `PIPE_OP_ADDIU, `PIPE_OP_ANDI, `PIPE_OP_ORI};
        sel = int'(r[31:28] % 4'd10);
        if (sel < 6)
            return enc_r(r[4:0], r[9:5], r[14:10], fns[sel]);
        return enc_i(ops[sel - 6], r[4:0], r[9:5], r[25:10]);
    endfunction

    // expected commit as {commits, is_exc, reg or code, data or pc}.
    function automatic logic [38:0] predict(input logic [31:0] w, input logic [31:0] p,
                                            input logic v);
        logic [5:0] op;
        logic [5:0] fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [4:0] dst;
        longint exact;
        logic trap;
        op = w[31:26];
        fn = w[5:0];
        a = rf_val(w[25:21]);
        b = rf_val(w[20:16]);
        dst = w[15:11];
        r = '0;
        exact = 0;
        trap = 1'b0;
        if (!v || w == '0)
            return '0;
        if (p[1:0] != 2'b00)
            return {2'b11, `PIPE_EXC_ADEL, p};
        if (op == `PIPE_OP_RTYPE)
        begin
            case (fn)
                `PIPE_FN_SYSCALL: return {2'b11, `PIPE_EXC_SYS, p};
                `PIPE_FN_BREAK: return {2'b11, `PIPE_EXC_BP, p};
                `PIPE_FN_ADD, `PIPE_FN_ADDU:
                begin
                    r = a + b;
                    exact = longint'($signed(a)) + longint'($signed(b));
                end
                `PIPE_FN_SUB, `PIPE_FN_SUBU:
                begin
                    r = a - b;
                    exact = longint'($signed(a)) - longint'($signed(b));
                end
                `PIPE_FN_AND: r = a & b;
                `PIPE_FN_OR: r = a | b;
                default: return {2'b11, `PIPE_EXC_RI, p};
            endcase
            trap = (fn == `PIPE_FN_ADD) || (fn == `PIPE_FN_SUB);
        end
        else
        begin
            dst = w[20:16];
            b = {{16{w[15]}}, w[15:0]};
            case (op)
                `PIPE_OP_ADDI:
                begin
                    r = a + b;
                    exact = longint'($signed(a)) + longint'($signed(b));
                    trap = 1'b1;
                end
                `PIPE_OP_ADDIU: r = a + b;
                `PIPE_OP_ANDI: r = a & {16'h0, w[15:0]};
                `PIPE_OP_ORI: r = a | {16'h0, w[15:0]};
                default: return {2'b11, `PIPE_EXC_RI, p};
            endcase
        end
        // the exact result does not fit in 32 signed bits.
        if (trap && (exact != longint'($signed(r))))
            return {2'b11, `PIPE_EXC_OV, p};
        if (dst == 5'd0)
            return '0;
        return {2'b10, dst, r};
    endfunction

    task automatic add_row(input int t, input logic [31:0] w, input logic [31:0] p,
                           input logic v, input int h, input int l, input logic f);
        row_test[n_rows] = t;
        row_ins[n_rows] = w;
        row_pc[n_rows] = p;
        row_valid[n_rows] = v;
        row_hold[n_rows] = h;
        row_lvl[n_rows] = l;
        row_flush[n_rows] = f;
        if (h > max_hold)
            max_hold = h;
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] w;
        n_rows = 0;
        max_hold = 0;
        add_row(0, enc_r(5'd4, 5'd5, 5'd6, `PIPE_FN_ADD), 32'h1000, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_r(5'd7, 5'd8, 5'd9, `PIPE_FN_ADDU), 32'h1004, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_r(5'd10, 5'd11, 5'd12, `PIPE_FN_SUB), 32'h1008, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_r(5'd13, 5'd14, 5'd15, `PIPE_FN_SUBU), 32'h100c, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_r(5'd16, 5'd17, 5'd18, `PIPE_FN_AND), 32'h1010, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_r(5'd19, 5'd20, 5'd21, `PIPE_FN_OR), 32'h1014, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_i(`PIPE_OP_ADDI, 5'd22, 5'd23, 16'h1234), 32'h1018, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_i(`PIPE_OP_ADDIU, 5'd24, 5'd25, 16'hff00), 32'h101c, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_i(`PIPE_OP_ANDI, 5'd26, 5'd27, 16'hf0f0), 32'h1020, 1'b1, 0, 0, 1'b0);
        add_row(0, enc_i(`PIPE_OP_ORI, 5'd28, 5'd29, 16'h8001), 32'h1024, 1'b1, 0, 0, 1'b0);
        // each trapping form next to its non-trapping twin on the same operands.
        add_row(1, enc_r(5'd1, 5'd1, 5'd8, `PIPE_FN_ADD), 32'h2000, 1'b1, 0, 0, 1'b0);
        add_row(1, enc_r(5'd1, 5'd1, 5'd9, `PIPE_FN_ADDU), 32'h2004, 1'b1, 0, 0, 1'b0);
        add_row(1, enc_i(`PIPE_OP_ADDI, 5'd1, 5'd10, 16'h7fff), 32'h2008, 1'b1, 0, 0, 1'b0);
        add_row(1, enc_i(`PIPE_OP_ADDIU, 5'd1, 5'd11, 16'h7fff), 32'h200c, 1'b1, 0, 0, 1'b0);
        add_row(1, enc_r(5'd3, 5'd2, 5'd12, `PIPE_FN_SUB), 32'h2010, 1'b1, 0, 0, 1'b0);
        add_row(1, enc_r(5'd3, 5'd2, 5'd13, `PIPE_FN_SUBU), 32'h2014, 1'b1, 0, 0, 1'b0);
        add_row(2, enc_r(5'd0, 5'd0, 5'd0, `PIPE_FN_SYSCALL), 32'h3000, 1'b1, 0, 0, 1'b0);
        add_row(2, enc_r(5'd0, 5'd0, 5'd0, `PIPE_FN_BREAK), 32'h3004, 1'b1, 0, 0, 1'b0);
        add_row(2, enc_r(5'd4, 5'd5, 5'd6, 6'h3f), 32'h3008, 1'b1, 0, 0, 1'b0);
        add_row(2, enc_i(6'h3f, 5'd4, 5'd5, 16'h0), 32'h300c, 1'b1, 0, 0, 1'b0);
        add_row(2, enc_r(5'd4, 5'd5, 5'd6, `PIPE_FN_ADD), 32'h3012, 1'b1, 0, 0, 1'b0);
        add_row(2, enc_i(6'h3f, 5'd4, 5'd5, 16'h0), 32'h3021, 1'b1, 0, 0, 1'b0);
        add_row(3, enc_r(5'd4, 5'd5, 5'd6, `PIPE_FN_ADD), 32'h4000, 1'b0, 0, 0, 1'b0);
        add_row(3, enc_r(5'd4, 5'd5, 5'd0, `PIPE_FN_ADD), 32'h4004, 1'b1, 0, 0, 1'b0);
        add_row(3, enc_i(`PIPE_OP_ADDI, 5'd4, 5'd0, 16'h0011), 32'h4008, 1'b1, 0, 0, 1'b0);
        add_row(3, 32'h0, 32'h400c, 1'b1, 0, 0, 1'b0);
        add_row(3, enc_r(5'd5, 5'd4, 5'd7, `PIPE_FN_OR), 32'h4010, 1'b1, 0, 0, 1'b0);
        for (int k = 0; k < 24; k++)
        begin
            rng = xorshift(rng);
            w = random_ins(rng);
            rng = xorshift(rng);
            add_row(4, w, {16'h0, rng[15:2], 2'b00}, 1'b1, int'(rng[17:16]),
                    1 + int'(rng[23:18] % 6'd3), 1'b0);
        end
        add_row(5, enc_r(5'd4, 5'd5, 5'd6, `PIPE_FN_ADD), 32'h6000, 1'b1, 0, 0, 1'b0);
        add_row(5, enc_r(5'd7, 5'd8, 5'd9, `PIPE_FN_SUB), 32'h6004, 1'b1, 0, 0, 1'b0);
        add_row(5, enc_i(`PIPE_OP_ORI, 5'd10, 5'd11, 16'h00ff), 32'h6008, 1'b1, 0, 0, 1'b0);
        add_row(5, enc_r(5'd12, 5'd13, 5'd14, `PIPE_FN_ADDU), 32'h600c, 1'b1, 0, 0, 1'b1);
        add_row(5, enc_r(5'd15, 5'd16, 5'd17, `PIPE_FN_AND), 32'h6010, 1'b1, 0, 0, 1'b0);
        add_row(5, enc_r(5'd18, 5'd19, 5'd20, `PIPE_FN_OR), 32'h6014, 1'b1, 0, 0, 1'b0);
        add_row(5, enc_i(`PIPE_OP_ADDI, 5'd21, 5'd22, 16'h8000), 32'h6018, 1'b1, 0, 0, 1'b0);
    endtask

    task automatic check(input string name, input logic [63:0] want, input logic [63:0] got);
        checks++;
        test_checks++;
        if (want !== got)
        begin
            errors++;
            test_errors++;
            $display("mismatch in %s: expected %h, actual %h", name, want, got);
        end
    endtask

    // the output is consumed at the next edge unless the result stage stalls.
    task automatic observe(input logic sr);
        logic [37:0] want;
        logic [37:0] got;
        int lat;
        if ((wb_en || exc_valid) && !sr)
        begin
            got = wb_en ? {1'b0, wb_reg, wb_data} : {1'b1, exc_code, exc_pc};
            if (exp_q.size() == 0)
            begin
                errors++;
                test_errors++;
                $display("test %s: a commit appeared when none was expected",
                         test_name[cur_test]);
            end
            else
            begin
                want = exp_q.pop_front();
                lat = cyc - cyc_q.pop_front();
                check(test_name[cur_test], 64'(want), 64'(got));
                if (timed[cur_test])
                    check({test_name[cur_test], " latency"}, 64'(3), 64'(lat));
            end
        end
    endtask

    task automatic apply_cycle(input logic [31:0] i_ins, input logic [31:0] i_pc,
                               input logic i_valid, input int lvl, input logic i_flush);
        logic [38:0] pred;
        @(negedge clk);
        observe(lvl >= 3);
        if (i_flush)
        begin
            exp_q.delete();
            cyc_q.delete();
        end
        stall_decode = (lvl >= 1);
        stall_exec = (lvl >= 2);
        stall_result = (lvl >= 3);
        flush = i_flush;
        ins = i_ins;
        pc = i_pc;
        ins_valid = i_valid;
        pred = predict(i_ins, i_pc, i_valid);
        if (lvl == 0 && !i_flush && pred[38])
        begin
            exp_q.push_back(pred[37:0]);
            cyc_q.push_back(cyc);
        end
    endtask

    task automatic run_test(input int t);
        cur_test = t;
        test_checks = 0;
        test_errors = 0;
        for (int r = 0; r < n_rows; r++)
        begin
            if (row_test[r] == t)
            begin
                // fetches offered during a stall are dropped.
                for (int h = 0; h < row_hold[r]; h++)
                    apply_cycle(row_ins[r], row_pc[r], row_valid[r], row_lvl[r], 1'b0);
                apply_cycle(row_ins[r], row_pc[r], row_valid[r], 0, row_flush[r]);
            end
        end
        repeat (4) apply_cycle('0, '0, 1'b0, 0, 1'b0);
        if (exp_q.size() != 0)
        begin
            errors++;
            test_errors++;
            $display("test %s: %0d expected commits never appeared", test_name[t], exp_q.size());
            exp_q.delete();
            cyc_q.delete();
        end
        $display("test %s: %0d checks, %0d errors", test_name[t], test_checks, test_errors);
    endtask

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        rst = 1'b1;
        flush = 1'b0;
        stall_decode = 1'b0;
        stall_exec = 1'b0;
        stall_result = 1'b0;
        pc = '0;
        ins = '0;
        ins_valid = 1'b0;
        checks = 0;
        errors = 0;
        rng = 32'd8753;
        build_table();
        limit = n_rows * (3 + max_hold) + 64;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < 6; t++)
            run_test(t);
        errors += pipe_top_i.pipe_assert_i.fail_count;
        $display("%0d checks, %0d errors in total", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+source
source/pipe_pkg.sv
source/stage_reg.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/pipe_top.sv
bench/pipe_assert.sv
bench/pipe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipe_tb -f all.f -o pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/pipe_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "simulation reported failure"
exit 1
